/* all.f */
hdl/lsu_pkg.sv
hdl/axi_lite_if.sv
hdl/lsu_op_if.sv
hdl/lsu_decode.sv
hdl/lsu_execute.sv
hdl/lsu_result.sv
hdl/axi_sram.sv
hdl/lsu_top.sv
sim/lsu_properties.sv
sim/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f all.f -o lsu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/lsu_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
	echo "testbench reported failure"
	exit 1
fi

echo "run finished, see $log"
exit 0

/* sim/lsu_tb.sv */
`timescale 1ns/10ps

module lsu_tb;

	localparam int MEM_WORDS = 256;
	// cycles allowed for any single wait
	localparam int LIMIT = 100;

	logic clk = 1'b0;
	logic rst;
	logic req_valid;
	logic req_ready;
	lsu_pkg::width_t req_width;
	logic req_store;
	lsu_pkg::addr_t req_base;
	logic [11:0] req_offset;
	lsu_pkg::dword_t req_wdata;
	logic res_valid;
	logic res_ready;
	lsu_pkg::dword_t res_data;
	logic res_err;

	// reference memory, one entry per byte
	logic [7:0] model [MEM_WORDS * 8];
	// {err, data} per request, oldest first
	logic [64:0] expected [$];

	logic [31:0] lfsr;
	logic [31:0] bp_lfsr;
	logic bp_on;
	string test_name;
	int checks = 0;
	int errors = 0;
	int test_checks;
	int test_errors;
	bit aborted = 1'b0;

	lsu_top #(
		.MEM_WORDS(MEM_WORDS)
	) uut (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_width(req_width),
		.req_store(req_store),
		.req_base(req_base),
		.req_offset(req_offset),
		.req_wdata(req_wdata),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_data(res_data),
		.res_err(res_err)
	);

	always #50 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	function automatic logic [63:0] rnd(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic lsu_pkg::dword_t fill_word(input lsu_pkg::addr_t a);
		return {a ^ 32'h9e3779b9, ~a};
	endfunction

	// kind 0 aligned in range, 1 misaligned, 2 past the array end
	function automatic lsu_pkg::addr_t pick_addr(input logic [1:0] size, input int kind);
		lsu_pkg::addr_t a;
		lsu_pkg::addr_t n;
		n = lsu_pkg::addr_t'(1) << size;
		if (kind == 2)
			a = (lsu_pkg::addr_t'(MEM_WORDS) + lsu_pkg::addr_t'(rnd(16))) << 3;
		else
			a = lsu_pkg::addr_t'(rnd(32)) % lsu_pkg::addr_t'(MEM_WORDS * 8);
		a = a & ~(n - 1);
		if (kind == 1)
			a = a + 1 + lsu_pkg::addr_t'(rnd(3)) % (n - 1);
		return a;
	endfunction

	// expected {err, data}; stores update the model
	function automatic logic [64:0] model_access(input lsu_pkg::width_t w, input logic st,
			input lsu_pkg::addr_t base, input logic [11:0] off, input lsu_pkg::dword_t wd);
		lsu_pkg::addr_t eff;
		lsu_pkg::dword_t v;
		int n;
		eff = base + {{20{off[11]}}, off};
		n = 1 << w[1:0];
		if ((eff[2:0] & 3'(n - 1)) != 3'd0 || eff[31:3] >= 29'(MEM_WORDS))
			return {1'b1, 64'd0};
		if (st) begin
			for (int i = 0; i < n; i++)
				model[eff + i] = wd[8*i +: 8];
			return {1'b0, 64'd0};
		end
		v = '0;
		for (int i = 0; i < n; i++)
			v[8*i +: 8] = model[eff + i];
		// funct3 bit 2 means zero-extend
		if (!w[2] && n < 8 && v[8*n-1])
			v = v | ~((64'd1 << (8 * n)) - 64'd1);
		return {1'b0, v};
	endfunction

	task automatic end_run;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0 && !aborted)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	endtask

	// one request, random offset, base chosen to land on eff
	task automatic access(input lsu_pkg::width_t w, input logic st, input lsu_pkg::addr_t eff,
			input lsu_pkg::dword_t wd);
		logic [11:0] off;
		int t;
		off = 12'(rnd(12));
		req_base = eff - {{20{off[11]}}, off};
		req_offset = off;
		req_width = w;
		req_store = st;
		req_wdata = wd;
		req_valid = 1'b1;
		expected.push_back(model_access(w, st, req_base, off, wd));
		t = 0;
		@(negedge clk);
		while (!req_ready && t < LIMIT) begin
			@(negedge clk);
			t++;
		end
		if (!req_ready) begin
			$display("timeout: request not accepted within %0d cycles in %s", LIMIT, test_name);
			aborted = 1'b1;
			end_run();
		end
		@(posedge clk);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	// wait for every outstanding result, then report the test
	task automatic finish_test;
		int t;
		t = 0;
		while (expected.size() != 0 && t < LIMIT * 4) begin
			@(negedge clk);
			t++;
		end
		if (expected.size() != 0) begin
			$display("timeout: %0d results never arrived in %s", expected.size(), test_name);
			aborted = 1'b1;
			end_run();
		end
		@(posedge clk);
		#1;
		$display("test %s: %0d checks, %0d errors", test_name, checks - test_checks,
			errors - test_errors);
	endtask

	// res_ready, random only while back-pressure is on
	always @(posedge clk) begin
		logic bp_now;
		bp_now = bp_on;
		#1;
		if (bp_now) begin
			bp_lfsr = lfsr_next(bp_lfsr);
			res_ready = bp_lfsr[0];
		end else begin
			res_ready = 1'b1;
		end
	end

	// both sides are stable here, transfer follows on the next rising edge
	always @(negedge clk) begin
		logic [64:0] want;
		if (!rst && res_valid && res_ready) begin
			assert (expected.size() != 0)
			else begin
				errors++;
				$display("result appeared with no request outstanding in %s", test_name);
			end
			if (expected.size() != 0) begin
				want = expected.pop_front();
				checks++;
				assert (res_err === want[64] && res_data === want[63:0])
				else begin
					errors++;
					$display("error %s: expected err=%0b data=%h, actual err=%0b data=%h",
						test_name, want[64], want[63:0], res_err, res_data);
				end
			end
		end
	end

	initial begin
		lsu_pkg::width_t w;
		lsu_pkg::addr_t a;
		logic st;
		int kind;
		lfsr = 32'hcc9;
		bp_lfsr = 32'hcc9;
		bp_on = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req_width = '0;
		req_store = 1'b0;
		req_base = '0;
		req_offset = '0;
		req_wdata = '0;
		res_ready = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		// every word gets an address pattern before any load
		start_test("fill");
		for (int i = 0; i < MEM_WORDS; i++)
			access(3'd3, 1'b1, lsu_pkg::addr_t'(i * 8), fill_word(lsu_pkg::addr_t'(i * 8)));
		finish_test();

		start_test("widths");
		for (int i = 0; i < 150; i++) begin
			st = rnd(1) != 0;
			w = lsu_pkg::width_t'(rnd(3));
			// no unsigned store codes
			if (st)
				w[2] = 1'b0;
			access(w, st, pick_addr(w[1:0], 0), rnd(64));
		end
		finish_test();

		// byte or half store, then the whole word
		start_test("partial_store");
		for (int i = 0; i < 24; i++) begin
			w = lsu_pkg::width_t'(rnd(1));
			a = pick_addr(w[1:0], 0);
			access(w, 1'b1, a, rnd(64));
			access(3'd3, 1'b0, {a[31:3], 3'b000}, '0);
		end
		finish_test();

		start_test("misaligned");
		for (int i = 0; i < 24; i++) begin
			w = lsu_pkg::width_t'(1 + rnd(2) % 3);
			st = rnd(1) != 0;
			a = pick_addr(w[1:0], 1);
			access(w, st, a, rnd(64));
			access(3'd3, 1'b0, {a[31:3], 3'b000}, '0);
		end
		finish_test();

		start_test("out_of_range");
		for (int i = 0; i < 16; i++) begin
			w = lsu_pkg::width_t'(rnd(2));
			a = pick_addr(w[1:0], 2);
			access(w, 1'b1, a, rnd(64));
			access(w, 1'b0, a, '0);
		end
		finish_test();

		// mixed traffic, requests back to back
		start_test("back_pressure");
		bp_on = 1'b1;
		for (int i = 0; i < 200; i++) begin
			st = rnd(1) != 0;
			w = lsu_pkg::width_t'(rnd(3));
			if (st)
				w[2] = 1'b0;
			kind = int'(rnd(3));
			if (kind == 0 && w[1:0] != 2'd0)
				kind = 1;
			else if (kind == 1)
				kind = 2;
			else
				kind = 0;
			access(w, st, pick_addr(w[1:0], kind), rnd(64));
		end
		finish_test();
		bp_on = 1'b0;

		// idle tail, any stray result is caught by the checker
		repeat (10) @(posedge clk);
		end_run();
	end

endmodule

/* sim/lsu_properties.sv */
`timescale 1ns/10ps

module lsu_properties (
	input logic clk,
	input logic rst,
	input logic arvalid,
	input logic arready,
	input lsu_pkg::addr_t araddr,
	input logic rvalid,
	input logic rready,
	input lsu_pkg::dword_t rdata,
	input lsu_pkg::resp_t rresp,
	input logic awvalid,
	input logic awready,
	input lsu_pkg::addr_t awaddr,
	input logic wvalid,
	input logic wready,
	input lsu_pkg::dword_t wdata,
	input lsu_pkg::strb_t wstrb,
	input logic bvalid,
	input logic bready,
	input lsu_pkg::resp_t bresp,
	input logic res_valid,
	input logic res_ready,
	input lsu_pkg::dword_t res_data,
	input logic res_err
);

	// read address held until arready
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("read address dropped or changed before arready");

	// sram keeps r up until rready
	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("read data dropped or changed before rready");

	aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("write address dropped or changed before awready");

	w_hold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else $error("write data dropped or changed before wready");

	b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response dropped or changed before bready");

	// result slot under back-pressure
	res_hold: assert property (@(posedge clk) disable iff (rst)
		res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_err))
		else $error("result dropped or changed before res_ready");

	// from the second reset cycle on, the link is quiet
	bus_quiet: assert property (@(posedge clk)
		rst && $past(rst) |-> !(arvalid || rvalid || awvalid || wvalid || bvalid))
		else $error("bus valid seen while in reset");

	res_after_reset: assert property (@(posedge clk) $fell(rst) |-> !res_valid)
		else $error("res_valid high right after reset");

endmodule

// the bus is reached through the link instance inside the top level
bind lsu_top lsu_properties props (
	.clk(clk),
	.rst(rst),
	.arvalid(axi_link.arvalid),
	.arready(axi_link.arready),
	.araddr(axi_link.araddr),
	.rvalid(axi_link.rvalid),
	.rready(axi_link.rready),
	.rdata(axi_link.rdata),
	.rresp(axi_link.rresp),
	.awvalid(axi_link.awvalid),
	.awready(axi_link.awready),
	.awaddr(axi_link.awaddr),
	.wvalid(axi_link.wvalid),
	.wready(axi_link.wready),
	.wdata(axi_link.wdata),
	.wstrb(axi_link.wstrb),
	.bvalid(axi_link.bvalid),
	.bready(axi_link.bready),
	.bresp(axi_link.bresp),
	.res_valid(res_valid),
	.res_ready(res_ready),
	.res_data(res_data),
	.res_err(res_err)
);

/* hdl/lsu_top.sv */
`timescale 1ns/10ps

module lsu_top #(
	parameter int MEM_WORDS = 256
) (
	input logic clk,
	input logic rst,
	input logic req_valid,
	output logic req_ready,
	input lsu_pkg::width_t req_width,
	input logic req_store,
	input lsu_pkg::addr_t req_base,
	input logic [11:0] req_offset,
	input lsu_pkg::dword_t req_wdata,
	output logic res_valid,
	input logic res_ready,
	output lsu_pkg::dword_t res_data,
	output logic res_err
);

	// completion from execute to result
	logic done;
	logic done_store;
	logic [2:0] done_addr_lo;
	lsu_pkg::width_t done_width;
	lsu_pkg::dword_t done_data;
	logic done_err;
	logic res_free;

	lsu_op_if op_link ();
	axi_lite_if axi_link ();

	lsu_decode u_decode (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_width(req_width),
		.req_store(req_store),
		.req_base(req_base),
		.req_offset(req_offset),
		.req_wdata(req_wdata),
		.op(op_link.op_source)
	);

	lsu_execute u_execute (
		.clk(clk),
		.rst(rst),
		.res_free(res_free),
		.op(op_link.op_sink),
		.bus(axi_link.master),
		.done(done),
		.done_store(done_store),
		.done_addr_lo(done_addr_lo),
		.done_width(done_width),
		.done_data(done_data),
		.done_err(done_err)
	);

	lsu_result u_result (
		.clk(clk),
		.rst(rst),
		.done(done),
		.done_store(done_store),
		.done_addr_lo(done_addr_lo),
		.done_width(done_width),
		.done_data(done_data),
		.done_err(done_err),
		.res_ready(res_ready),
		.res_free(res_free),
		.res_valid(res_valid),
		.res_data(res_data),
		.res_err(res_err)
	);

	axi_sram #(
		.MEM_WORDS(MEM_WORDS)
	) u_sram (
		.clk(clk),
		.rst(rst),
		.bus(axi_link.slave)
	);

endmodule

/* hdl/axi_sram.sv */
`timescale 1ns/10ps

module axi_sram #(
	parameter int MEM_WORDS = 256
) (
	input logic clk,
	input logic rst,
	axi_lite_if.slave bus
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	lsu_pkg::dword_t mem [MEM_WORDS];

	lsu_pkg::sram_rd_state_t rd_state;
	lsu_pkg::sram_wr_state_t wr_state;
	logic [28:0] rd_word;
	logic [28:0] wr_word;
	logic rd_hit;
	logic wr_hit;
	logic rd_go;
	logic wr_go;

	// word index and range check per channel
	assign rd_word = bus.araddr[31:3];
	assign wr_word = bus.awaddr[31:3];
	assign rd_hit = (rd_word < 29'(MEM_WORDS));
	assign wr_hit = (wr_word < 29'(MEM_WORDS));

	// read side
	assign bus.arready = (rd_state == lsu_pkg::RD_IDLE);
	assign bus.rvalid = (rd_state == lsu_pkg::RD_RESP);
	assign rd_go = bus.arvalid && bus.arready;

	always_ff @(posedge clk) begin
		if (rst)
			rd_state <= lsu_pkg::RD_IDLE;
		else if (rd_go)
			rd_state <= lsu_pkg::RD_RESP;
		else if (bus.rvalid && bus.rready)
			rd_state <= lsu_pkg::RD_IDLE;
	end

	always_ff @(posedge clk) begin
		if (rd_go) begin
			bus.rdata <= rd_hit ? mem[rd_word[IDX_W-1:0]] : '0;
			bus.rresp <= rd_hit ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
		end
	end

	// write side, address and data taken together
	assign bus.awready = (wr_state == lsu_pkg::WR_IDLE);
	assign bus.wready = (wr_state == lsu_pkg::WR_IDLE);
	assign bus.bvalid = (wr_state == lsu_pkg::WR_RESP);
	assign wr_go = bus.awvalid && bus.wvalid && (wr_state == lsu_pkg::WR_IDLE);

	always_ff @(posedge clk) begin
		if (rst)
			wr_state <= lsu_pkg::WR_IDLE;
		else if (wr_go)
			wr_state <= lsu_pkg::WR_RESP;
		else if (bus.bvalid && bus.bready)
			wr_state <= lsu_pkg::WR_IDLE;
	end

	always_ff @(posedge clk) begin
		if (wr_go)
			bus.bresp <= wr_hit ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
	end

	// byte lanes under wstrb, nothing stored out of range
	always_ff @(posedge clk) begin
		if (wr_go && wr_hit) begin
			for (int i = 0; i < 8; i++) begin
				if (bus.wstrb[i])
					mem[wr_word[IDX_W-1:0]][i*8 +: 8] <= bus.wdata[i*8 +: 8];
			end
		end
	end

endmodule

/* hdl/lsu_result.sv */
`timescale 1ns/10ps

module lsu_result (
	input logic clk,
	input logic rst,
	input logic done,
	input logic done_store,
	input logic [2:0] done_addr_lo,
	input lsu_pkg::width_t done_width,
	input lsu_pkg::dword_t done_data,
	input logic done_err,
	input logic res_ready,
	output logic res_free,
	output logic res_valid,
	output lsu_pkg::dword_t res_data,
	output logic res_err
);

	lsu_pkg::dword_t shifted;
	lsu_pkg::dword_t extended;
	logic zext;

	// move the addressed bytes down to lane 0
	assign shifted = done_data >> {done_addr_lo, 3'b000};
	assign zext = done_width[2];

	always_comb begin
		case (done_width[1:0])
			lsu_pkg::SIZE_B: extended = {{56{!zext && shifted[7]}}, shifted[7:0]};
			lsu_pkg::SIZE_H: extended = {{48{!zext && shifted[15]}}, shifted[15:0]};
			lsu_pkg::SIZE_W: extended = {{32{!zext && shifted[31]}}, shifted[31:0]};
			default: extended = shifted;
		endcase
	end

	// slot empty, or being read out this cycle
	assign res_free = !res_valid || res_ready;

	always_ff @(posedge clk) begin
		if (rst)
			res_valid <= 1'b0;
		else if (done && res_free)
			res_valid <= 1'b1;
		else if (res_ready)
			res_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (done && res_free) begin
			// stores and errors carry no data
			res_data <= (done_store || done_err) ? '0 : extended;
			res_err <= done_err;
		end
	end

endmodule

/* hdl/lsu_execute.sv */
`timescale 1ns/10ps

module lsu_execute (
	input logic clk,
	input logic rst,
	input logic res_free,
	lsu_op_if.op_sink op,
	axi_lite_if.master bus,
	output logic done,
	output logic done_store,
	output logic [2:0] done_addr_lo,
	output lsu_pkg::width_t done_width,
	output lsu_pkg::dword_t done_data,
	output logic done_err
);

	lsu_pkg::exec_state_t state;
	logic take;

	// one op at a time, taken only when idle
	assign op.ready = (state == lsu_pkg::EX_IDLE);
	assign take = op.valid && op.ready;

	assign done = (state == lsu_pkg::EX_RESULT);
	assign bus.rready = (state == lsu_pkg::EX_READ);
	assign bus.bready = (state == lsu_pkg::EX_WRITE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= lsu_pkg::EX_IDLE;
			bus.arvalid <= 1'b0;
			bus.awvalid <= 1'b0;
			bus.wvalid <= 1'b0;
		end else begin
			case (state)
				lsu_pkg::EX_IDLE: begin
					if (take) begin
						// misaligned ops never reach the bus
						if (op.misaligned) begin
							state <= lsu_pkg::EX_RESULT;
						end else if (op.store) begin
							state <= lsu_pkg::EX_WRITE;
							bus.awvalid <= 1'b1;
							bus.wvalid <= 1'b1;
						end else begin
							state <= lsu_pkg::EX_READ;
							bus.arvalid <= 1'b1;
						end
					end
				end
				lsu_pkg::EX_READ: begin
					if (bus.arready)
						bus.arvalid <= 1'b0;
					if (bus.rvalid)
						state <= lsu_pkg::EX_RESULT;
				end
				lsu_pkg::EX_WRITE: begin
					// aw and w may be taken separately
					if (bus.awready)
						bus.awvalid <= 1'b0;
					if (bus.wready)
						bus.wvalid <= 1'b0;
					if (bus.bvalid)
						state <= lsu_pkg::EX_RESULT;
				end
				lsu_pkg::EX_RESULT: begin
					// hold done until result stage has room
					if (res_free)
						state <= lsu_pkg::EX_IDLE;
				end
				default: state <= lsu_pkg::EX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			// bus always sees word-aligned addresses
			bus.araddr <= {op.addr[31:3], 3'b000};
			bus.awaddr <= {op.addr[31:3], 3'b000};
			bus.wdata <= op.wdata;
			bus.wstrb <= op.strb;
			done_store <= op.store;
			done_addr_lo <= op.addr[2:0];
			done_width <= op.width;
			done_data <= '0;
			done_err <= op.misaligned;
		end
		if (state == lsu_pkg::EX_READ && bus.rvalid) begin
			done_data <= bus.rdata;
			done_err <= (bus.rresp != lsu_pkg::RESP_OKAY);
		end
		if (state == lsu_pkg::EX_WRITE && bus.bvalid)
			done_err <= (bus.bresp != lsu_pkg::RESP_OKAY);
	end

endmodule

/* hdl/lsu_decode.sv */
`timescale 1ns/10ps

module lsu_decode (
	input logic clk,
	input logic rst,
	input logic req_valid,
	output logic req_ready,
	input lsu_pkg::width_t req_width,
	input logic req_store,
	input lsu_pkg::addr_t req_base,
	input logic [11:0] req_offset,
	input lsu_pkg::dword_t req_wdata,
	lsu_op_if.op_source op
);

	lsu_pkg::addr_t eff_addr;
	lsu_pkg::strb_t strb;
	lsu_pkg::dword_t lane_data;
	logic misaligned;
	logic live;
	logic accept;

	// base plus sign-extended 12-bit offset
	assign eff_addr = req_base + {{20{req_offset[11]}}, req_offset};

	// alignment, strobe and lane replication per size
	always_comb begin
		case (req_width[1:0])
			lsu_pkg::SIZE_B: begin
				misaligned = 1'b0;
				strb = 8'h01 << eff_addr[2:0];
				lane_data = {8{req_wdata[7:0]}};
			end
			lsu_pkg::SIZE_H: begin
				misaligned = eff_addr[0];
				strb = 8'h03 << eff_addr[2:0];
				lane_data = {4{req_wdata[15:0]}};
			end
			lsu_pkg::SIZE_W: begin
				misaligned = |eff_addr[1:0];
				strb = 8'h0f << eff_addr[2:0];
				lane_data = {2{req_wdata[31:0]}};
			end
			default: begin
				misaligned = |eff_addr[2:0];
				strb = 8'hff;
				lane_data = req_wdata;
			end
		endcase
	end

	// keeps req_ready low until the cycle after reset
	always_ff @(posedge clk) begin
		if (rst)
			live <= 1'b0;
		else
			live <= 1'b1;
	end

	// slot empty, or draining this cycle
	assign req_ready = live && (!op.valid || op.ready);
	assign accept = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (rst)
			op.valid <= 1'b0;
		else if (accept)
			op.valid <= 1'b1;
		else if (op.ready)
			op.valid <= 1'b0;
	end

	// op payload
	always_ff @(posedge clk) begin
		if (accept) begin
			op.addr <= eff_addr;
			op.strb <= strb;
			op.wdata <= lane_data;
			op.width <= req_width;
			op.store <= req_store;
			op.misaligned <= misaligned;
		end
	end

endmodule

/* hdl/lsu_op_if.sv */
`timescale 1ns/10ps

interface lsu_op_if;

	logic valid;
	logic ready;
	// effective byte address, not yet word aligned
	lsu_pkg::addr_t addr;
	lsu_pkg::strb_t strb;
	// store data already placed on its lanes
	lsu_pkg::dword_t wdata;
	lsu_pkg::width_t width;
	logic store;
	logic misaligned;

	modport op_source (output valid, addr, strb, wdata, width, store, misaligned, input ready);
	modport op_sink (input valid, addr, strb, wdata, width, store, misaligned, output ready);

endinterface

/* hdl/axi_lite_if.sv */
`timescale 1ns/10ps

interface axi_lite_if;

	// read address
	lsu_pkg::addr_t araddr;
	logic arvalid;
	logic arready;
	// read data
	lsu_pkg::dword_t rdata;
	lsu_pkg::resp_t rresp;
	logic rvalid;
	logic rready;
	// write address
	lsu_pkg::addr_t awaddr;
	logic awvalid;
	logic awready;
	// write data
	lsu_pkg::dword_t wdata;
	lsu_pkg::strb_t wstrb;
	logic wvalid;
	logic wready;
	// write response
	lsu_pkg::resp_t bresp;
	logic bvalid;
	logic bready;

	modport master (
		output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

	modport slave (
		input araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

endinterface

/* hdl/lsu_pkg.sv */
package lsu_pkg;

	// byte address on the link
	typedef logic [31:0] addr_t;
	// one memory word, also the AXI data width
	typedef logic [63:0] dword_t;
	// one bit per byte lane
	typedef logic [7:0] strb_t;
	typedef logic [1:0] resp_t;
	// funct3: size in [1:0], zero-extend in [2]
	typedef logic [2:0] width_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	// size field of funct3
	localparam logic [1:0] SIZE_B = 2'd0;
	localparam logic [1:0] SIZE_H = 2'd1;
	localparam logic [1:0] SIZE_W = 2'd2;
	localparam logic [1:0] SIZE_D = 2'd3;

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_READ,
		EX_WRITE,
		EX_RESULT
	} exec_state_t;

	typedef enum logic {RD_IDLE, RD_RESP} sram_rd_state_t;
	typedef enum logic {WR_IDLE, WR_RESP} sram_wr_state_t;

endpackage
